/* croc_periph_top.f */
design/croc_periph_pkg.sv
design/reg_bus_if.sv
design/pulser_channel.sv
design/pulser_regs.sv
design/gpio_regs.sv
design/axil_reg_bridge.sv
design/croc_periph_top.sv
tb/croc_periph_assert.sv
tb/tb_croc_periph_top.sv

/* design/axil_reg_bridge.sv */
// AXI4-Lite subordinate that decodes the peripheral index and drives the register buses
`timescale 1ns/1ps
`default_nettype none

module axil_reg_bridge import croc_periph_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_n_i,
  input  addr_t     s_axil_awaddr_i,
  input  logic      s_axil_awvalid_i,
  output logic      s_axil_awready_o,
  input  data_t     s_axil_wdata_i,
  input  strb_t     s_axil_wstrb_i,
  input  logic      s_axil_wvalid_i,
  output logic      s_axil_wready_o,
  output axi_resp_e s_axil_bresp_o,
  output logic      s_axil_bvalid_o,
  input  logic      s_axil_bready_i,
  input  addr_t     s_axil_araddr_i,
  input  logic      s_axil_arvalid_i,
  output logic      s_axil_arready_o,
  output data_t     s_axil_rdata_o,
  output axi_resp_e s_axil_rresp_o,
  output logic      s_axil_rvalid_o,
  input  logic      s_axil_rready_i,
  reg_bus_if.host   gpio_bus,
  reg_bus_if.host   pulser_bus
);

  logic        rsp_pending;
  logic        wr_start;
  logic        rd_start;
  addr_t       acc_addr;
  periph_sel_e acc_sel;
  data_t       acc_rdata;
  axi_resp_e   acc_resp;
  logic        bvalid_q;
  logic        rvalid_q;
  axi_resp_e   bresp_q;
  axi_resp_e   rresp_q;
  data_t       rdata_q;

  // ------------------------------
  // Handshake
  // ------------------------------
  // One transaction at a time, write wins over read
  assign rsp_pending = bvalid_q | rvalid_q;
  assign wr_start    = s_axil_awvalid_i & s_axil_wvalid_i & ~rsp_pending;
  assign rd_start    = s_axil_arvalid_i & ~wr_start & ~rsp_pending;

  assign s_axil_awready_o = wr_start;
  assign s_axil_wready_o  = wr_start;
  assign s_axil_arready_o = rd_start;

  // ------------------------------
  // Address decode
  // ------------------------------
  assign acc_addr = wr_start ? s_axil_awaddr_i : s_axil_araddr_i;
  assign acc_sel  = periph_sel_e'(acc_addr[PeriphSelLsb +: PeriphSelWidth]);

  always_comb begin
    acc_rdata = ErrRspData;
    acc_resp  = RespOkay;
    case (acc_sel)
      PeriphGpio:   acc_rdata = gpio_bus.rdata;
      PeriphPulser: acc_rdata = pulser_bus.rdata;
      default:      acc_resp  = RespSlvErr;
    endcase
  end

  // Only the selected bus sees req, the rest is shared
  assign gpio_bus.req     = (wr_start | rd_start) & (acc_sel == PeriphGpio);
  assign gpio_bus.we      = wr_start;
  assign gpio_bus.addr    = reg_addr_t'(acc_addr[RegAddrLsb +: RegAddrWidth]);
  assign gpio_bus.wdata   = s_axil_wdata_i;
  assign gpio_bus.be      = s_axil_wstrb_i;

  assign pulser_bus.req   = (wr_start | rd_start) & (acc_sel == PeriphPulser);
  assign pulser_bus.we    = wr_start;
  assign pulser_bus.addr  = reg_addr_t'(acc_addr[RegAddrLsb +: RegAddrWidth]);
  assign pulser_bus.wdata = s_axil_wdata_i;
  assign pulser_bus.be    = s_axil_wstrb_i;

  // ------------------------------
  // Response channels
  // ------------------------------
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end else begin
      if (wr_start) begin
        bvalid_q <= 1'b1;
      end else if (s_axil_bready_i) begin
        bvalid_q <= 1'b0;
      end
      if (rd_start) begin
        rvalid_q <= 1'b1;
      end else if (s_axil_rready_i) begin
        rvalid_q <= 1'b0;
      end
    end
  end

  // Held constant until the manager takes it
  always_ff @(posedge clk_i) begin
    if (wr_start) begin
      bresp_q <= acc_resp;
    end
    if (rd_start) begin
      rdata_q <= acc_rdata;
      rresp_q <= acc_resp;
    end
  end

  assign s_axil_bvalid_o = bvalid_q;
  assign s_axil_bresp_o  = bresp_q;
  assign s_axil_rvalid_o = rvalid_q;
  assign s_axil_rdata_o  = rdata_q;
  assign s_axil_rresp_o  = rresp_q;

endmodule

`default_nettype wire

/* design/croc_periph_pkg.sv */
// Peripheral subsystem package: bus types, address map fields and error response data
`default_nettype none

package croc_periph_pkg;

  // Bus word and address types
  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0]  strb_t;

  typedef enum logic [1:0] {
    RespOkay   = 2'b00,
    RespSlvErr = 2'b10
  } axi_resp_e;

  // ------------------------------
  // Address map
  // ------------------------------
  // Word offset inside a peripheral sits at bits 3..2
  localparam int unsigned RegAddrLsb     = 2;
  localparam int unsigned RegAddrWidth   = 2;
  // Peripheral index sits at bits 11..8
  localparam int unsigned PeriphSelLsb   = 8;
  localparam int unsigned PeriphSelWidth = 4;

  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  typedef enum logic [PeriphSelWidth-1:0] {
    PeriphGpio   = 4'd0,
    PeriphPulser = 4'd1
  } periph_sel_e;

  // Returned on reads from unmapped space
  localparam data_t ErrRspData = 32'hbadcab1e;

  // Byte-wise merge of write data into an old register value
  function automatic data_t apply_strb(data_t old_val, data_t new_val, strb_t strb);
    data_t merged;
    merged = old_val;
    for (int b = 0; b < $bits(strb_t); b++) begin
      if (strb[b]) begin
        merged[8*b +: 8] = new_val[8*b +: 8];
      end
    end
    return merged;
  endfunction

endpackage

`default_nettype wire

/* design/croc_periph_top.sv */
// Peripheral subsystem top: AXI4-Lite port bridged to GPIO and pulser registers
`timescale 1ns/1ps
`default_nettype none

module croc_periph_top import croc_periph_pkg::*; #(
  parameter int unsigned GpioCount     = 16,
  parameter int unsigned NumPulsers    = 4,
  parameter int unsigned PulseCntWidth = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  // AXI4-Lite subordinate
  input  addr_t                 s_axil_awaddr_i,
  input  logic                  s_axil_awvalid_i,
  output logic                  s_axil_awready_o,
  input  data_t                 s_axil_wdata_i,
  input  strb_t                 s_axil_wstrb_i,
  input  logic                  s_axil_wvalid_i,
  output logic                  s_axil_wready_o,
  output axi_resp_e             s_axil_bresp_o,
  output logic                  s_axil_bvalid_o,
  input  logic                  s_axil_bready_i,
  input  addr_t                 s_axil_araddr_i,
  input  logic                  s_axil_arvalid_i,
  output logic                  s_axil_arready_o,
  output data_t                 s_axil_rdata_o,
  output axi_resp_e             s_axil_rresp_o,
  output logic                  s_axil_rvalid_o,
  input  logic                  s_axil_rready_i,
  // Pins
  input  logic [GpioCount-1:0]  gpio_i,
  output logic [GpioCount-1:0]  gpio_o,
  output logic [GpioCount-1:0]  gpio_out_en_o,
  output logic [NumPulsers-1:0] pulse_o
);

  reg_bus_if gpio_bus ();
  reg_bus_if pulser_bus ();

  // ------------------------------
  // Bus bridge
  // ------------------------------
  axil_reg_bridge i_bridge (
    .clk_i,
    .rst_n_i,
    .s_axil_awaddr_i,
    .s_axil_awvalid_i,
    .s_axil_awready_o,
    .s_axil_wdata_i,
    .s_axil_wstrb_i,
    .s_axil_wvalid_i,
    .s_axil_wready_o,
    .s_axil_bresp_o,
    .s_axil_bvalid_o,
    .s_axil_bready_i,
    .s_axil_araddr_i,
    .s_axil_arvalid_i,
    .s_axil_arready_o,
    .s_axil_rdata_o,
    .s_axil_rresp_o,
    .s_axil_rvalid_o,
    .s_axil_rready_i,
    .gpio_bus   ( gpio_bus.host   ),
    .pulser_bus ( pulser_bus.host )
  );

  // ------------------------------
  // Peripherals
  // ------------------------------
  gpio_regs #(
    .GpioCount ( GpioCount )
  ) i_gpio (
    .clk_i,
    .rst_n_i,
    .bus ( gpio_bus.device ),
    .gpio_i,
    .gpio_o,
    .gpio_out_en_o
  );

  pulser_regs #(
    .NumPulsers    ( NumPulsers    ),
    .PulseCntWidth ( PulseCntWidth )
  ) i_pulser (
    .clk_i,
    .rst_n_i,
    .bus ( pulser_bus.device ),
    .pulse_o
  );

endmodule

`default_nettype wire

/* design/gpio_regs.sv */
// GPIO register block: direction, output and synchronised input
`timescale 1ns/1ps
`default_nettype none

module gpio_regs import croc_periph_pkg::*; #(
  parameter int unsigned GpioCount = 16
) (
  input  logic                 clk_i,
  input  logic                 rst_n_i,
  reg_bus_if.device            bus,
  input  logic [GpioCount-1:0] gpio_i,
  output logic [GpioCount-1:0] gpio_o,
  output logic [GpioCount-1:0] gpio_out_en_o
);

  localparam reg_addr_t DirOffs = 2'd0;
  localparam reg_addr_t OutOffs = 2'd1;
  localparam reg_addr_t InOffs  = 2'd2;

  logic [GpioCount-1:0] dir_q;
  logic [GpioCount-1:0] out_q;
  logic [GpioCount-1:0] in_meta_q;
  logic [GpioCount-1:0] in_sync_q;
  data_t                dir_wr;
  data_t                out_wr;

  assign dir_wr = apply_strb(data_t'(dir_q), bus.wdata, bus.be);
  assign out_wr = apply_strb(data_t'(out_q), bus.wdata, bus.be);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      dir_q <= '0;
      out_q <= '0;
    end else if (bus.req && bus.we) begin
      if (bus.addr == DirOffs) begin
        dir_q <= dir_wr[GpioCount-1:0];
      end
      if (bus.addr == OutOffs) begin
        out_q <= out_wr[GpioCount-1:0];
      end
    end
  end

  // Two-flop input synchroniser
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      in_meta_q <= '0;
      in_sync_q <= '0;
    end else begin
      in_meta_q <= gpio_i;
      in_sync_q <= in_meta_q;
    end
  end

  // Upper bits above GpioCount read as zero
  always_comb begin
    case (bus.addr)
      DirOffs: bus.rdata = data_t'(dir_q);
      OutOffs: bus.rdata = data_t'(out_q);
      InOffs:  bus.rdata = data_t'(in_sync_q);
      default: bus.rdata = '0;
    endcase
  end

  assign gpio_o        = out_q;
  assign gpio_out_en_o = dir_q;

endmodule

`default_nettype wire

/* design/pulser_channel.sv */
// Single pulser channel: wrapping counter with a one-cycle pulse per period
`timescale 1ns/1ps
`default_nettype none

module pulser_channel #(
  parameter int unsigned PulseCntWidth = 16
) (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic [PulseCntWidth-1:0] period_i,
  input  logic                     restart_i,
  output logic                     pulse_o
);

  logic [PulseCntWidth-1:0] cnt_q;
  logic [PulseCntWidth-1:0] last_cnt;
  logic                     wrap;
  logic                     pulse_q;

  // Period zero never wraps
  assign last_cnt = period_i - PulseCntWidth'(1);
  assign wrap     = (period_i != '0) && (cnt_q >= last_cnt);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i || restart_i) begin
      cnt_q   <= '0;
      pulse_q <= 1'b0;
    end else begin
      cnt_q   <= wrap ? '0 : cnt_q + PulseCntWidth'(1);
      pulse_q <= wrap;
    end
  end

  assign pulse_o = pulse_q;

endmodule

`default_nettype wire

/* design/pulser_regs.sv */
// Pulser register block: one period register per channel, steering the channel counters
`timescale 1ns/1ps
`default_nettype none

module pulser_regs import croc_periph_pkg::*; #(
  parameter int unsigned NumPulsers    = 4,
  parameter int unsigned PulseCntWidth = 16
) (
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  reg_bus_if.device             bus,
  output logic [NumPulsers-1:0] pulse_o
);

  logic [PulseCntWidth-1:0] period_q [NumPulsers];
  logic [NumPulsers-1:0]    restart;

  for (genvar k = 0; k < NumPulsers; k++) begin : gen_channel
    data_t period_wr;

    // A write to the period also restarts the channel
    assign restart[k] = bus.req && bus.we && (bus.addr == reg_addr_t'(k));
    assign period_wr  = apply_strb(data_t'(period_q[k]), bus.wdata, bus.be);

    always_ff @(posedge clk_i) begin
      if (!rst_n_i) begin
        period_q[k] <= '0;
      end else if (restart[k]) begin
        period_q[k] <= period_wr[PulseCntWidth-1:0];
      end
    end

    pulser_channel #(
      .PulseCntWidth ( PulseCntWidth )
    ) i_channel (
      .clk_i,
      .rst_n_i,
      .period_i  ( period_q[k] ),
      .restart_i ( restart[k]  ),
      .pulse_o   ( pulse_o[k]  )
    );
  end

  // Offsets past the last channel read zero
  always_comb begin
    bus.rdata = '0;
    for (int k = 0; k < NumPulsers; k++) begin
      if (bus.addr == reg_addr_t'(k)) begin
        bus.rdata = data_t'(period_q[k]);
      end
    end
  end

endmodule

`default_nettype wire

/* design/reg_bus_if.sv */
// Simple register bus between the AXI4-Lite bridge and one peripheral
`timescale 1ns/1ps
`default_nettype none

interface reg_bus_if import croc_periph_pkg::*; ();

  logic      req;
  logic      we;
  reg_addr_t addr;
  data_t     wdata;
  strb_t     be;
  // Combinational read data, follows addr
  data_t     rdata;

  modport host (
    output req, we, addr, wdata, be,
    input  rdata
  );

  modport device (
    input  req, we, addr, wdata, be,
    output rdata
  );

endinterface

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the peripheral subsystem testbench with Verilator and runs it

cd "$(dirname "$0")"
if [ $? -ne 0 ]; then
  echo "Cannot enter the project directory"
  exit 1
fi

verilator --binary --timing --assert -j 0 \
  --top-module tb_croc_periph_top \
  -f croc_periph_top.f \
  -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

sim_out="$(./obj_dir/sim_tb)"
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
  echo "Simulation exited with status $sim_status"
  exit 1
fi

if grep -qF 'All tests passed!' <<< "$sim_out"; then
  exit 0
fi
exit 1

/* tb/croc_periph_assert.sv */
// AXI4-Lite handshake checks bound into the register bridge
`timescale 1ns/1ps
`default_nettype none

module croc_periph_assert import croc_periph_pkg::*; (
  input logic      clk_i,
  input logic      rst_n_i,
  input logic      awready_i,
  input logic      bvalid_i,
  input logic      bready_i,
  input axi_resp_e bresp_i,
  input logic      rvalid_i,
  input logic      rready_i,
  input data_t     rdata_i,
  input axi_resp_e rresp_i
);

  // Responses stay up until taken
  bvalid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> bvalid_i)
    else $error("bvalid dropped before bready");

  rvalid_held: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> rvalid_i)
    else $error("rvalid dropped before rready");

  // Payload frozen while waiting
  bresp_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    bvalid_i && !bready_i |=> $stable(bresp_i))
    else $error("bresp changed while bvalid was waiting");

  rdata_stable: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i && !rready_i |=> $stable(rdata_i) && $stable(rresp_i))
    else $error("rdata or rresp changed while rvalid was waiting");

  // No new write while a response is pending
  no_aw_when_busy: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(awready_i && (bvalid_i || rvalid_i)))
    else $error("awready raised with a response pending");

endmodule

bind axil_reg_bridge croc_periph_assert assert_i (
  .clk_i     ( clk_i            ),
  .rst_n_i   ( rst_n_i          ),
  .awready_i ( s_axil_awready_o ),
  .bvalid_i  ( s_axil_bvalid_o  ),
  .bready_i  ( s_axil_bready_i  ),
  .bresp_i   ( s_axil_bresp_o   ),
  .rvalid_i  ( s_axil_rvalid_o  ),
  .rready_i  ( s_axil_rready_i  ),
  .rdata_i   ( s_axil_rdata_o   ),
  .rresp_i   ( s_axil_rresp_o   )
);

`default_nettype wire

/* tb/tb_croc_periph_top.sv */
// Testbench for the peripheral subsystem: random AXI4-Lite traffic checked against a model
`timescale 1ns/1ps
`default_nettype none

module tb_croc_periph_top import croc_periph_pkg::*; ();

  localparam int unsigned GpioCount     = 16;
  localparam int unsigned NumPulsers    = 4;
  localparam int unsigned PulseCntWidth = 16;
  // About 300 transactions at up to 12 cycles, plus the pulse windows
  localparam int unsigned MaxCycles     = 20000;

  typedef logic [GpioCount-1:0] gpio_t;

  logic                  clk;
  logic                  rst_n;
  addr_t                 s_axil_awaddr;
  logic                  s_axil_awvalid;
  logic                  s_axil_awready;
  data_t                 s_axil_wdata;
  strb_t                 s_axil_wstrb;
  logic                  s_axil_wvalid;
  logic                  s_axil_wready;
  axi_resp_e             s_axil_bresp;
  logic                  s_axil_bvalid;
  logic                  s_axil_bready;
  addr_t                 s_axil_araddr;
  logic                  s_axil_arvalid;
  logic                  s_axil_arready;
  data_t                 s_axil_rdata;
  axi_resp_e             s_axil_rresp;
  logic                  s_axil_rvalid;
  logic                  s_axil_rready;
  gpio_t                 gpio_in;
  gpio_t                 gpio_out;
  gpio_t                 gpio_out_en;
  logic [NumPulsers-1:0] pulse;

  // Register model
  gpio_t                    dir_m;
  gpio_t                    out_m;
  logic [PulseCntWidth-1:0] period_m [NumPulsers];

  logic [31:0] lfsr;
  int unsigned cycles       = 0;
  logic        verdict_done = 1'b0;
  int unsigned data_errs    = 0;
  int unsigned resp_errs    = 0;
  int unsigned gpio_errs    = 0;
  int unsigned pulse_errs   = 0;
  int unsigned other_errs   = 0;

  croc_periph_top #(
    .GpioCount     ( GpioCount     ),
    .NumPulsers    ( NumPulsers    ),
    .PulseCntWidth ( PulseCntWidth )
  ) dut_i (
    .clk_i            ( clk            ),
    .rst_n_i          ( rst_n          ),
    .s_axil_awaddr_i  ( s_axil_awaddr  ),
    .s_axil_awvalid_i ( s_axil_awvalid ),
    .s_axil_awready_o ( s_axil_awready ),
    .s_axil_wdata_i   ( s_axil_wdata   ),
    .s_axil_wstrb_i   ( s_axil_wstrb   ),
    .s_axil_wvalid_i  ( s_axil_wvalid  ),
    .s_axil_wready_o  ( s_axil_wready  ),
    .s_axil_bresp_o   ( s_axil_bresp   ),
    .s_axil_bvalid_o  ( s_axil_bvalid  ),
    .s_axil_bready_i  ( s_axil_bready  ),
    .s_axil_araddr_i  ( s_axil_araddr  ),
    .s_axil_arvalid_i ( s_axil_arvalid ),
    .s_axil_arready_o ( s_axil_arready ),
    .s_axil_rdata_o   ( s_axil_rdata   ),
    .s_axil_rresp_o   ( s_axil_rresp   ),
    .s_axil_rvalid_o  ( s_axil_rvalid  ),
    .s_axil_rready_i  ( s_axil_rready  ),
    .gpio_i           ( gpio_in        ),
    .gpio_o           ( gpio_out       ),
    .gpio_out_en_o    ( gpio_out_en    ),
    .pulse_o          ( pulse          )
  );

  initial clk = 1'b0;
  always #20 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      verdict_done = 1'b1;
      $display("Timeout: run stopped after %0d cycles without finishing", cycles);
      $display("Test failures found");
      $finish;
    end
  end

  // Run stopped early by a failing assertion
  final begin
    if (!verdict_done) begin
      $display("Test failures found");
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  // Fibonacci LFSR, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      r    = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic addr_t reg_addr(logic [3:0] sel, logic [1:0] offs);
    return {20'h0, sel, 4'h0, offs, 2'b00};
  endfunction

  function automatic data_t byte_merge(data_t old_val, data_t new_val, strb_t strb);
    data_t mask;
    for (int b = 0; b < 4; b++) begin
      mask[8*b +: 8] = {8{strb[b]}};
    end
    return (old_val & ~mask) | (new_val & mask);
  endfunction

  function automatic data_t gpio_model(logic [1:0] offs);
    if (offs == 2'd0) begin
      return data_t'(dir_m);
    end
    if (offs == 2'd1) begin
      return data_t'(out_m);
    end
    return '0;
  endfunction

  task automatic gpio_model_write(logic [1:0] offs, data_t wdata, strb_t strb);
    data_t merged;
    merged = byte_merge(gpio_model(offs), wdata, strb);
    if (offs == 2'd0) begin
      dir_m = merged[GpioCount-1:0];
    end else if (offs == 2'd1) begin
      out_m = merged[GpioCount-1:0];
    end
  endtask

  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  // ------------------------------
  // Compare tasks
  // ------------------------------
  task automatic check_data(string name, data_t exp, data_t act);
    if (act !== exp) begin
      data_errs++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_resp(string name, axi_resp_e exp, axi_resp_e act);
    if (act !== exp) begin
      resp_errs++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_gpio(string name, gpio_t exp, gpio_t act);
    if (act !== exp) begin
      gpio_errs++;
      $display("ERR %0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_pulse_gap(int unsigned ch, int unsigned exp, int unsigned act);
    if (act != exp) begin
      pulse_errs++;
      $display("ERR %0t pulse_o[%0d] gap expected %0d actual %0d", $time, ch, exp, act);
    end
  endtask

  task automatic note_failure(string msg);
    other_errs++;
    $display("%0t: %s", $time, msg);
  endtask

  // ------------------------------
  // Bus tasks
  // ------------------------------
  task automatic accept_write();
    @(negedge clk);
    while (!s_axil_awready) begin
      @(negedge clk);
    end
    if (!s_axil_wready) begin
      note_failure("wready was not raised together with awready");
    end
    step_cycle();
    s_axil_awvalid = 1'b0;
    s_axil_wvalid  = 1'b0;
  endtask

  task automatic accept_read();
    @(negedge clk);
    while (!s_axil_arready) begin
      @(negedge clk);
    end
    step_cycle();
    s_axil_arvalid = 1'b0;
  endtask

  // Holds bready low for a few random cycles
  task automatic take_write_rsp(output axi_resp_e resp);
    int unsigned stall;
    stall = rand_bits(2);
    if (!s_axil_bvalid) begin
      note_failure("write response not valid one cycle after the handshake");
    end
    repeat (stall) begin
      step_cycle();
    end
    s_axil_bready = 1'b1;
    @(negedge clk);
    resp = s_axil_bresp;
    step_cycle();
    s_axil_bready = 1'b0;
    if (s_axil_bvalid) begin
      note_failure("write response still valid after it was taken");
    end
  endtask

  task automatic take_read_rsp(output data_t data, output axi_resp_e resp);
    int unsigned stall;
    stall = rand_bits(2);
    if (!s_axil_rvalid) begin
      note_failure("read response not valid one cycle after the handshake");
    end
    repeat (stall) begin
      step_cycle();
    end
    s_axil_rready = 1'b1;
    @(negedge clk);
    data = s_axil_rdata;
    resp = s_axil_rresp;
    step_cycle();
    s_axil_rready = 1'b0;
    if (s_axil_rvalid) begin
      note_failure("read response still valid after it was taken");
    end
  endtask

  task automatic axil_write(addr_t addr, data_t data, strb_t strb, output axi_resp_e resp);
    s_axil_awaddr  = addr;
    s_axil_wdata   = data;
    s_axil_wstrb   = strb;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    accept_write();
    take_write_rsp(resp);
  endtask

  task automatic axil_read(addr_t addr, output data_t data, output axi_resp_e resp);
    s_axil_araddr  = addr;
    s_axil_arvalid = 1'b1;
    accept_read();
    take_read_rsp(data, resp);
  endtask

  // Write and read offered in the same cycle
  task automatic axil_write_read(addr_t waddr, data_t wdata, strb_t strb, addr_t raddr,
                                 output axi_resp_e bresp, output data_t rdata,
                                 output axi_resp_e rresp);
    s_axil_awaddr  = waddr;
    s_axil_wdata   = wdata;
    s_axil_wstrb   = strb;
    s_axil_araddr  = raddr;
    s_axil_awvalid = 1'b1;
    s_axil_wvalid  = 1'b1;
    s_axil_arvalid = 1'b1;
    #1;
    if (s_axil_arready) begin
      note_failure("read address accepted while a write was offered");
    end
    accept_write();
    take_write_rsp(bresp);
    if (s_axil_rvalid) begin
      note_failure("read response arrived before the write response was taken");
    end
    accept_read();
    take_read_rsp(rdata, rresp);
  endtask

  // ------------------------------
  // Tests
  // ------------------------------
  task automatic test_gpio_regs();
    logic [1:0] offs;
    data_t      wdata;
    strb_t      strb;
    data_t      rdata;
    axi_resp_e  resp;
    for (int i = 0; i < 40; i++) begin
      offs  = 2'(rand_bits(1));
      wdata = rand_bits(32);
      strb  = 4'(rand_bits(4));
      axil_write(reg_addr(PeriphGpio, offs), wdata, strb, resp);
      check_resp("bresp", RespOkay, resp);
      gpio_model_write(offs, wdata, strb);
      axil_read(reg_addr(PeriphGpio, offs), rdata, resp);
      check_resp("rresp", RespOkay, resp);
      check_data("rdata", gpio_model(offs), rdata);
      check_gpio("gpio_out_en_o", dir_m, gpio_out_en);
      check_gpio("gpio_o", out_m, gpio_out);
    end
    // Offset 3 is empty
    axil_write(reg_addr(PeriphGpio, 2'd3), rand_bits(32), 4'hf, resp);
    check_resp("bresp", RespOkay, resp);
    axil_read(reg_addr(PeriphGpio, 2'd3), rdata, resp);
    check_resp("rresp", RespOkay, resp);
    check_data("rdata", 32'h0, rdata);
  endtask

  task automatic test_gpio_input();
    data_t     rdata;
    axi_resp_e resp;
    for (int i = 0; i < 10; i++) begin
      gpio_in = gpio_t'(rand_bits(GpioCount));
      repeat (3) begin
        step_cycle();
      end
      axil_read(reg_addr(PeriphGpio, 2'd2), rdata, resp);
      check_resp("rresp", RespOkay, resp);
      check_data("rdata", data_t'(gpio_in), rdata);
    end
  endtask

  task automatic test_unmapped();
    logic [3:0] sel;
    logic [1:0] offs;
    data_t      rdata;
    axi_resp_e  resp;
    for (int i = 0; i < 20; i++) begin
      sel  = 4'(rand_bits(4));
      offs = 2'(rand_bits(2));
      if (sel < 4'd2) begin
        sel = sel + 4'd2;
      end
      axil_read(reg_addr(sel, offs), rdata, resp);
      check_data("rdata", 32'hbadcab1e, rdata);
      check_resp("rresp", RespSlvErr, resp);
      axil_write(reg_addr(sel, offs), rand_bits(32), 4'hf, resp);
      check_resp("bresp", RespSlvErr, resp);
    end
    // Mapped registers untouched
    for (int o = 0; o < 2; o++) begin
      axil_read(reg_addr(PeriphGpio, 2'(o)), rdata, resp);
      check_resp("rresp", RespOkay, resp);
      check_data("rdata", gpio_model(2'(o)), rdata);
    end
    for (int k = 0; k < NumPulsers; k++) begin
      axil_read(reg_addr(PeriphPulser, 2'(k)), rdata, resp);
      check_resp("rresp", RespOkay, resp);
      check_data("rdata", data_t'(period_m[k]), rdata);
    end
  endtask

  // Distance between consecutive high cycles must equal the period
  task automatic measure_pulse_gaps(int unsigned ch, int unsigned period);
    int unsigned last_hit;
    int unsigned gaps;
    logic        seen;
    last_hit = 0;
    gaps     = 0;
    seen     = 1'b0;
    for (int unsigned cyc = 0; cyc < 4 * period + 8 && gaps < 3; cyc++) begin
      @(negedge clk);
      if (pulse[ch]) begin
        if (seen) begin
          check_pulse_gap(ch, period, cyc - last_hit);
          gaps++;
        end
        seen     = 1'b1;
        last_hit = cyc;
      end
    end
    if (gaps < 3) begin
      note_failure($sformatf("too few pulses on channel %0d", ch));
    end
    step_cycle();
  endtask

  task automatic test_pulser();
    int unsigned period;
    int unsigned ch;
    logic        seen;
    data_t       rdata;
    axi_resp_e   resp;
    for (int k = 0; k < NumPulsers; k++) begin
      period = 1 + (rand_bits(6) % 40);
      axil_write(reg_addr(PeriphPulser, 2'(k)), data_t'(period), 4'hf, resp);
      check_resp("bresp", RespOkay, resp);
      period_m[k] = PulseCntWidth'(period);
      axil_read(reg_addr(PeriphPulser, 2'(k)), rdata, resp);
      check_resp("rresp", RespOkay, resp);
      check_data("rdata", data_t'(period_m[k]), rdata);
      measure_pulse_gaps(k, period);
    end
    // Period zero stops the channel
    ch = rand_bits(2) % NumPulsers;
    axil_write(reg_addr(PeriphPulser, 2'(ch)), 32'h0, 4'hf, resp);
    check_resp("bresp", RespOkay, resp);
    period_m[ch] = '0;
    seen = 1'b0;
    repeat (100) begin
      @(negedge clk);
      seen = seen | pulse[ch];
    end
    if (seen) begin
      note_failure($sformatf("channel %0d pulsed with a period of zero", ch));
    end
    step_cycle();
  endtask

  task automatic test_backpressure();
    logic [1:0] woffs;
    logic [1:0] roffs;
    data_t      wdata;
    strb_t      strb;
    data_t      rdata;
    axi_resp_e  bresp;
    axi_resp_e  rresp;
    for (int i = 0; i < 30; i++) begin
      woffs = 2'(rand_bits(1));
      roffs = 2'(rand_bits(1));
      wdata = rand_bits(32);
      strb  = 4'(rand_bits(4));
      axil_write_read(reg_addr(PeriphGpio, woffs), wdata, strb, reg_addr(PeriphGpio, roffs),
                      bresp, rdata, rresp);
      gpio_model_write(woffs, wdata, strb);
      check_resp("bresp", RespOkay, bresp);
      check_resp("rresp", RespOkay, rresp);
      check_data("rdata", gpio_model(roffs), rdata);
    end
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    lfsr           = 32'hc470;
    rst_n          = 1'b0;
    s_axil_awaddr  = '0;
    s_axil_awvalid = 1'b0;
    s_axil_wdata   = '0;
    s_axil_wstrb   = '0;
    s_axil_wvalid  = 1'b0;
    s_axil_bready  = 1'b0;
    s_axil_araddr  = '0;
    s_axil_arvalid = 1'b0;
    s_axil_rready  = 1'b0;
    gpio_in        = '0;
    dir_m          = '0;
    out_m          = '0;
    for (int k = 0; k < NumPulsers; k++) begin
      period_m[k] = '0;
    end

    repeat (10) begin
      @(posedge clk);
    end
    #2;
    rst_n = 1'b1;
    if (s_axil_awready || s_axil_arready || s_axil_bvalid || s_axil_rvalid) begin
      note_failure("ready or valid high right after reset");
    end
    check_gpio("gpio_o", '0, gpio_out);
    check_gpio("gpio_out_en_o", '0, gpio_out_en);
    if (pulse !== '0) begin
      note_failure("pulse output high right after reset");
    end

    test_gpio_regs();
    test_gpio_input();
    test_unmapped();
    test_pulser();
    test_backpressure();

    verdict_done = 1'b1;
    $display("Error counts: data %0d, response %0d, gpio %0d, pulse %0d, other %0d",
             data_errs, resp_errs, gpio_errs, pulse_errs, other_errs);
    if (data_errs + resp_errs + gpio_errs + pulse_errs + other_errs == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire
